//--- src/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

	typedef logic [31:0] instr_word_t;

	// primary opcodes
	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_REGIMM = 6'h01, OP_J     = 6'h02, OP_JAL   = 6'h03,
		OP_BEQ     = 6'h04, OP_BNE    = 6'h05, OP_BLEZ  = 6'h06, OP_BGTZ  = 6'h07,
		OP_ADDI    = 6'h08, OP_ADDIU  = 6'h09, OP_SLTI  = 6'h0a, OP_SLTIU = 6'h0b,
		OP_ANDI    = 6'h0c, OP_ORI    = 6'h0d, OP_XORI  = 6'h0e, OP_LUI   = 6'h0f,
		OP_LB      = 6'h20, OP_LH     = 6'h21, OP_LW    = 6'h23, OP_LBU   = 6'h24,
		OP_LHU     = 6'h25, OP_SB     = 6'h28, OP_SH    = 6'h29, OP_SW    = 6'h2b
	} opcode_e;

	// SPECIAL function field
	typedef enum logic [5:0] {
		FN_SLL  = 6'h00, FN_SRL   = 6'h02, FN_SRA     = 6'h03, FN_SLLV  = 6'h04,
		FN_SRLV = 6'h06, FN_SRAV  = 6'h07, FN_JR      = 6'h08, FN_JALR  = 6'h09,
		FN_SYSCALL = 6'h0c, FN_BREAK = 6'h0d, FN_MFHI = 6'h10, FN_MTHI  = 6'h11,
		FN_MFLO = 6'h12, FN_MTLO  = 6'h13, FN_MULT    = 6'h18, FN_MULTU = 6'h19,
		FN_DIV  = 6'h1a, FN_DIVU  = 6'h1b, FN_ADD     = 6'h20, FN_ADDU  = 6'h21,
		FN_SUB  = 6'h22, FN_SUBU  = 6'h23, FN_AND     = 6'h24, FN_OR    = 6'h25,
		FN_XOR  = 6'h26, FN_NOR   = 6'h27, FN_SLT     = 6'h2a, FN_SLTU  = 6'h2b
	} funct_e;

	// REGIMM rt field
	typedef enum logic [4:0] {
		RI_BLTZ   = 5'h00,
		RI_BGEZ   = 5'h01,
		RI_BLTZAL = 5'h10,
		RI_BGEZAL = 5'h11
	} regimm_e;

	// nine classes, so four bits
	typedef enum logic [3:0] {
		CLS_NOP, CLS_R_TYPE, CLS_REGIMM, CLS_IMM_ALU, CLS_LOAD,
		CLS_STORE, CLS_BRANCH, CLS_JUMP, CLS_UNKNOWN
	} instr_class_e;

	typedef enum logic [4:0] {
		ALU_NONE, ALU_ADD, ALU_ADDU, ALU_SUB, ALU_SUBU, ALU_SLT, ALU_SLTU,
		ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLLV, ALU_SRLV, ALU_SRAV, ALU_LUI,
		ALU_MEM, ALU_MFHI, ALU_MFLO, ALU_MTHI, ALU_MTLO,
		ALU_MULT, ALU_MULTU, ALU_DIV, ALU_DIVU, ALU_LINK
	} alu_op_e;

	typedef enum logic [2:0] {
		BR_NONE, BR_EQ, BR_NE, BR_LEZ, BR_GTZ, BR_LTZ, BR_GEZ, BR_ALWAYS
	} branch_cond_e;

	typedef struct packed {
		logic [5:0]   op;
		logic [4:0]   rs;
		logic [4:0]   rt;
		logic [4:0]   rd;
		logic [4:0]   shamt;
		logic [5:0]   funct;
		logic [15:0]  imm16;
		instr_class_e cls;
	} instr_fields_t;

	typedef struct packed {
		alu_op_e      alu_op;
		branch_cond_e branch_cond;
		logic [4:0]   dest;
		logic         regwrite;
		logic         is_imm;
		logic         sign_ex;
		logic         mem_read;
		logic         mem_write;
		logic         memtoreg;
		logic         read_rs;
		logic         read_rt;
		logic         hilo_read;
		logic         hilo_write;
		logic         muldiv_en;
		logic         solo;
		logic         ri;
		logic         syscall;
		logic         brk;
	} ctrl_t;

	localparam logic [4:0] LINK_REG = 5'd31;

endpackage

`default_nettype wire

//--- src/predecode_latch.sv
`timescale 1ns/10ps
`default_nettype none

module predecode_latch #(
	parameter int ISSUE_WIDTH = 2
) (
	input  wire                            clk,
	input  wire                            rst_n,
	input  wire                            in_valid,
	input  wire mips_decode_pkg::instr_word_t in_group [ISSUE_WIDTH],
	output logic                           lat_valid,
	output mips_decode_pkg::instr_fields_t lat_fields [ISSUE_WIDTH]
);
	import mips_decode_pkg::*;

	function automatic instr_class_e classify(input instr_word_t w);
		if (w == '0)
			return CLS_NOP;
		case (w[31:26])
			OP_SPECIAL: return CLS_R_TYPE;
			OP_REGIMM:  return CLS_REGIMM;
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU,
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: return CLS_IMM_ALU;
			OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU: return CLS_LOAD;
			OP_SB, OP_SH, OP_SW: return CLS_STORE;
			OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: return CLS_BRANCH;
			OP_J, OP_JAL: return CLS_JUMP;
			default: return CLS_UNKNOWN;
		endcase
	endfunction

	function automatic instr_fields_t split(input instr_word_t w);
		instr_fields_t f;
		f.op    = w[31:26];
		f.rs    = w[25:21];
		f.rt    = w[20:16];
		f.rd    = w[15:11];
		f.shamt = w[10:6];
		f.funct = w[5:0];
		f.imm16 = w[15:0];
		f.cls   = classify(w);
		return f;
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			lat_valid <= 1'b0;
		else
			lat_valid <= in_valid;
	end

	// fields only load on a strobe
	always_ff @(posedge clk) begin
		if (in_valid) begin
			for (int i = 0; i < ISSUE_WIDTH; i++) begin
				lat_fields[i] <= split(in_group[i]);
			end
		end
	end

endmodule

`default_nettype wire

//--- src/slot_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module slot_decoder (
	input  wire mips_decode_pkg::instr_fields_t fields,
	output mips_decode_pkg::ctrl_t              ctrl
);
	import mips_decode_pkg::*;

	logic rsvd;

	function automatic alu_op_e funct_alu(input logic [5:0] fn);
		case (fn)
			FN_ADD:   return ALU_ADD;
			FN_ADDU:  return ALU_ADDU;
			FN_SUB:   return ALU_SUB;
			FN_SUBU:  return ALU_SUBU;
			FN_SLT:   return ALU_SLT;
			FN_SLTU:  return ALU_SLTU;
			FN_AND:   return ALU_AND;
			FN_OR:    return ALU_OR;
			FN_XOR:   return ALU_XOR;
			FN_NOR:   return ALU_NOR;
			FN_SLL:   return ALU_SLL;
			FN_SRL:   return ALU_SRL;
			FN_SRA:   return ALU_SRA;
			FN_SLLV:  return ALU_SLLV;
			FN_SRLV:  return ALU_SRLV;
			FN_SRAV:  return ALU_SRAV;
			FN_MFHI:  return ALU_MFHI;
			FN_MFLO:  return ALU_MFLO;
			FN_MTHI:  return ALU_MTHI;
			FN_MTLO:  return ALU_MTLO;
			FN_MULT:  return ALU_MULT;
			FN_MULTU: return ALU_MULTU;
			FN_DIV:   return ALU_DIV;
			FN_DIVU:  return ALU_DIVU;
			FN_JALR:  return ALU_LINK;
			default:  return ALU_NONE;
		endcase
	endfunction

	always_comb begin
		ctrl = '0;
		rsvd = 1'b0;
		case (fields.cls)
			CLS_R_TYPE: begin
				ctrl.alu_op = funct_alu(fields.funct);
				ctrl.dest   = fields.rd;
				case (fields.funct)
					FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_SLT, FN_SLTU, FN_AND, FN_OR,
					FN_XOR, FN_NOR, FN_SLLV, FN_SRLV, FN_SRAV: begin
						ctrl.regwrite = 1'b1;
						ctrl.read_rs  = 1'b1;
						ctrl.read_rt  = 1'b1;
					end
					// shift amount comes from shamt
					FN_SLL, FN_SRL, FN_SRA: begin
						ctrl.regwrite = 1'b1;
						ctrl.read_rt  = 1'b1;
					end
					FN_JR: begin
						ctrl.branch_cond = BR_ALWAYS;
						ctrl.read_rs     = 1'b1;
					end
					FN_JALR: begin
						ctrl.branch_cond = BR_ALWAYS;
						ctrl.read_rs     = 1'b1;
						ctrl.regwrite    = 1'b1;
						ctrl.dest        = LINK_REG;
					end
					FN_MFHI, FN_MFLO: begin
						ctrl.hilo_read = 1'b1;
						ctrl.regwrite  = 1'b1;
					end
					FN_MTHI, FN_MTLO: begin
						ctrl.hilo_write = 1'b1;
						ctrl.read_rs    = 1'b1;
					end
					FN_MULT, FN_MULTU, FN_DIV, FN_DIVU: begin
						ctrl.muldiv_en = 1'b1;
						ctrl.read_rs   = 1'b1;
						ctrl.read_rt   = 1'b1;
					end
					FN_SYSCALL: ctrl.syscall = 1'b1;
					FN_BREAK:   ctrl.brk = 1'b1;
					default:    rsvd = 1'b1;
				endcase
			end
			CLS_IMM_ALU: begin
				ctrl.dest     = fields.rt;
				ctrl.regwrite = 1'b1;
				ctrl.is_imm   = 1'b1;
				ctrl.read_rs  = (fields.op != OP_LUI);
				case (fields.op)
					OP_ADDI:  ctrl.alu_op = ALU_ADD;
					OP_ADDIU: ctrl.alu_op = ALU_ADDU;
					OP_SLTI:  ctrl.alu_op = ALU_SLT;
					OP_SLTIU: ctrl.alu_op = ALU_SLTU;
					OP_ANDI:  ctrl.alu_op = ALU_AND;
					OP_ORI:   ctrl.alu_op = ALU_OR;
					OP_XORI:  ctrl.alu_op = ALU_XOR;
					OP_LUI:   ctrl.alu_op = ALU_LUI;
					default:  rsvd = 1'b1;
				endcase
			end
			CLS_LOAD: begin
				ctrl.alu_op   = ALU_MEM;
				ctrl.dest     = fields.rt;
				ctrl.regwrite = 1'b1;
				ctrl.is_imm   = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.memtoreg = 1'b1;
				ctrl.solo     = 1'b1;
				ctrl.read_rs  = 1'b1;
			end
			CLS_STORE: begin
				ctrl.alu_op    = ALU_MEM;
				ctrl.is_imm    = 1'b1;
				ctrl.mem_write = 1'b1;
				ctrl.solo      = 1'b1;
				ctrl.read_rs   = 1'b1;
				ctrl.read_rt   = 1'b1;
			end
			CLS_BRANCH: begin
				ctrl.read_rs = 1'b1;
				ctrl.read_rt = (fields.op == OP_BEQ) || (fields.op == OP_BNE);
				case (fields.op)
					OP_BEQ:  ctrl.branch_cond = BR_EQ;
					OP_BNE:  ctrl.branch_cond = BR_NE;
					OP_BLEZ: ctrl.branch_cond = BR_LEZ;
					default: ctrl.branch_cond = BR_GTZ;
				endcase
			end
			CLS_REGIMM: begin
				ctrl.read_rs = 1'b1;
				case (fields.rt)
					RI_BLTZ, RI_BLTZAL: ctrl.branch_cond = BR_LTZ;
					RI_BGEZ, RI_BGEZAL: ctrl.branch_cond = BR_GEZ;
					default: rsvd = 1'b1;
				endcase
				// the AL forms write the return address
				if (fields.rt == RI_BLTZAL || fields.rt == RI_BGEZAL) begin
					ctrl.alu_op   = ALU_LINK;
					ctrl.dest     = LINK_REG;
					ctrl.regwrite = 1'b1;
				end
			end
			CLS_JUMP: begin
				ctrl.branch_cond = BR_ALWAYS;
				if (fields.op == OP_JAL) begin
					ctrl.alu_op   = ALU_LINK;
					ctrl.dest     = LINK_REG;
					ctrl.regwrite = 1'b1;
				end
			end
			CLS_UNKNOWN: rsvd = 1'b1;
			default: ;
		endcase

		if (fields.cls != CLS_NOP)
			ctrl.sign_ex = !(fields.op inside {OP_ANDI, OP_ORI, OP_XORI, OP_LUI});
		if (!ctrl.regwrite)
			ctrl.dest = '0;
		if (rsvd) begin
			ctrl    = '0;
			ctrl.ri = 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/issue_group_check.sv
`timescale 1ns/10ps
`default_nettype none

module issue_group_check #(
	parameter int ISSUE_WIDTH = 2
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               lat_valid,
	input  wire mips_decode_pkg::instr_fields_t lat_fields [ISSUE_WIDTH],
	input  wire mips_decode_pkg::ctrl_t       slot_ctrl [ISSUE_WIDTH],
	output logic                              out_valid,
	output mips_decode_pkg::ctrl_t            out_ctrl [ISSUE_WIDTH],
	output logic [$clog2(ISSUE_WIDTH+1)-1:0]  issue_count
);
	import mips_decode_pkg::*;

	localparam int CNT_W = $clog2(ISSUE_WIDTH + 1);

	logic [CNT_W-1:0] count;

	always_comb begin
		logic        go;
		logic        stop;
		logic        hilo_busy;
		logic        raw;
		logic [31:0] wr_mask;
		go        = 1'b1;
		stop      = 1'b0;
		hilo_busy = 1'b0;
		raw       = 1'b0;
		wr_mask   = '0;
		count     = '0;
		for (int k = 0; k < ISSUE_WIDTH; k++) begin
			// reads of $0 never conflict
			raw = (slot_ctrl[k].read_rs && lat_fields[k].rs != 5'd0 && wr_mask[lat_fields[k].rs]) ||
			      (slot_ctrl[k].read_rt && lat_fields[k].rt != 5'd0 && wr_mask[lat_fields[k].rt]);
			if (k != 0)
				go = go && !stop && !slot_ctrl[k].solo && !raw &&
				     !(slot_ctrl[k].hilo_read && hilo_busy);
			count = count + CNT_W'(go);
			stop = stop | slot_ctrl[k].solo | slot_ctrl[k].ri;
			hilo_busy = hilo_busy | slot_ctrl[k].hilo_write | slot_ctrl[k].muldiv_en;
			if (slot_ctrl[k].regwrite)
				wr_mask[slot_ctrl[k].dest] = 1'b1;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid   <= 1'b0;
			issue_count <= '0;
			out_ctrl    <= '{default: '0};
		end else begin
			out_valid <= lat_valid;
			// hold last group when idle
			if (lat_valid) begin
				issue_count <= count;
				out_ctrl    <= slot_ctrl;
			end
		end
	end

endmodule

`default_nettype wire

//--- src/mips_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mips_decode_stage #(
	parameter int ISSUE_WIDTH = 2
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  wire                               in_valid,
	input  wire mips_decode_pkg::instr_word_t in_group [ISSUE_WIDTH],
	output logic                              out_valid,
	output mips_decode_pkg::ctrl_t            out_ctrl [ISSUE_WIDTH],
	output logic [$clog2(ISSUE_WIDTH+1)-1:0]  issue_count
);
	import mips_decode_pkg::*;

	logic          lat_valid;
	instr_fields_t lat_fields [ISSUE_WIDTH];
	ctrl_t         slot_ctrl [ISSUE_WIDTH];

	predecode_latch #(
		.ISSUE_WIDTH(ISSUE_WIDTH)
	) u_latch (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_group  (in_group),
		.lat_valid (lat_valid),
		.lat_fields(lat_fields)
	);

	// one decoder per slot
	for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_slot
		slot_decoder u_slot (
			.fields(lat_fields[i]),
			.ctrl  (slot_ctrl[i])
		);
	end

	issue_group_check #(
		.ISSUE_WIDTH(ISSUE_WIDTH)
	) u_check (
		.clk        (clk),
		.rst_n      (rst_n),
		.lat_valid  (lat_valid),
		.lat_fields (lat_fields),
		.slot_ctrl  (slot_ctrl),
		.out_valid  (out_valid),
		.out_ctrl   (out_ctrl),
		.issue_count(issue_count)
	);

endmodule

`default_nettype wire

//--- sim/tb_clock_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen #(
	parameter int HALF_PERIOD  = 10,
	parameter int RESET_CYCLES = 8
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

	// release just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- sim/tb_mips_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_decode_stage;
	import mips_decode_pkg::*;

	localparam int NUM_GROUPS = 23;
	localparam int COLS       = 5;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	instr_word_t in_group [2];
	logic        out_valid;
	ctrl_t       out_ctrl [2];
	logic [1:0]  issue_count;

	// instr0, instr1, count, ctrl0, ctrl1 per group
	logic [31:0] pat_mem [NUM_GROUPS*COLS];

	// cycle at which each group's output is due
	int due_at [NUM_GROUPS];
	int sent = 0;
	int recv = 0;
	int cyc  = 0;

	logic [31:0] lcg_state = 32'h7707;

	tb_clock_gen u_clk (
		.clk  (clk),
		.rst_n(rst_n)
	);

	mips_decode_stage #(
		.ISSUE_WIDTH(2)
	) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.in_valid   (in_valid),
		.in_group   (in_group),
		.out_valid  (out_valid),
		.out_ctrl   (out_ctrl),
		.issue_count(issue_count)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state;
	endfunction

	task automatic abort_run(input string why);
		$display("ERROR at %0t: %s", $time, why);
		$display("*** TEST FAILED ***");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
			abort_run("value mismatch");
		end
	endtask

	// outputs are stable at the falling edge
	always @(negedge clk) begin
		cyc = cyc + 1;
		if (rst_n && out_valid) begin
			if (recv >= sent) begin
				abort_run("out_valid pulsed with no group outstanding");
			end else begin
				check_value("out_valid cycle", 32'(cyc), 32'(due_at[recv]));
				check_value("issue_count", 32'(issue_count), pat_mem[recv*COLS+2]);
				check_value("out_ctrl[0]", 32'(out_ctrl[0]), pat_mem[recv*COLS+3]);
				check_value("out_ctrl[1]", 32'(out_ctrl[1]), pat_mem[recv*COLS+4]);
				recv = recv + 1;
			end
		end else if (rst_n && recv < sent && due_at[recv] <= cyc) begin
			abort_run("out_valid did not arrive for an outstanding group");
		end
	end

	initial begin
		int          wait_cnt;
		int          gap;
		logic [31:0] r;
		in_valid    = 1'b0;
		in_group[0] = '0;
		in_group[1] = '0;
		$readmemh("sim/decode_patterns.txt", pat_mem);

		wait_cnt = 0;
		while (rst_n !== 1'b1) begin
			@(posedge clk);
			wait_cnt = wait_cnt + 1;
			if (wait_cnt > 20)
				abort_run("reset was never released");
		end
		@(posedge clk);
		#1;
		check_value("out_valid after reset", 32'(out_valid), 32'd0);
		check_value("issue_count after reset", 32'(issue_count), 32'd0);
		check_value("out_ctrl[0] after reset", 32'(out_ctrl[0]), 32'd0);
		check_value("out_ctrl[1] after reset", 32'(out_ctrl[1]), 32'd0);

		for (int g = 0; g < NUM_GROUPS; g++) begin
			r   = next_random();
			gap = int'(r[17:16]);
			repeat (gap) begin
				in_valid = 1'b0;
				@(posedge clk);
				#1;
			end
			in_valid    = 1'b1;
			in_group[0] = pat_mem[g*COLS];
			in_group[1] = pat_mem[g*COLS+1];
			// sampled at the next edge and seen on out_valid two cycles later
			due_at[g] = cyc + 3;
			sent      = sent + 1;
			@(posedge clk);
			#1;
		end
		in_valid = 1'b0;

		wait_cnt = 0;
		while (recv < sent) begin
			@(posedge clk);
			wait_cnt = wait_cnt + 1;
			if (wait_cnt > 10)
				abort_run("timed out waiting for outstanding groups");
		end
		// a few idle cycles to catch stray pulses
		repeat (4) @(posedge clk);
		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- sim/decode_patterns.txt
// columns: instr0 instr1 issue_count ctrl0 ctrl1 (hex)
// ctrl is the 28-bit control bundle, alu_op in the top bits
00221820 348500ff 2 081D180 402E100
00073100 2128ffff 2 5835080 0847100
016C502B 3C0D1234 2 3055180 886E000
8FA20008 00851820 1 9017B08 081D180
AFA60004 01093825 1 9003588 403D180
00221821 A0A40000 1 101D180 9003588
00221820 00652022 1 081D180 1825180
00220021 00062824 2 1005180 382D180
00220018 00001810 1 B801190 981D040
00800013 00002812 1 B001120 A02D040
00C7001B 01000011 2 D001190 A801120
0C000100 0120F809 2 DFFD000 DFFD100
04900010 04B10020 2 DDFD100 DEFD100
10220004 1464FFFC 2 0101180 0201180
18A00008 1CC00008 2 0301100 0401100
04E00003 08000040 2 0501100 0701000
03E00008 05010005 2 0701100 0601100
FC221820 00221820 1 0000004 081D180
00221801 00000000 1 0000004 0000000
00000000 04230000 2 0000000 0000004
0000000C 0000000D 2 0001002 0001001
3041F0F0 38230001 1 380E100 481E100
28A4FFFB 01073007 2 2827100 8035180

//--- mips_decode_stage.f
src/mips_decode_pkg.sv
src/predecode_latch.sv
src/slot_decoder.sv
src/issue_group_check.sv
src/mips_decode_stage.sv
sim/tb_clock_gen.sv
sim/tb_mips_decode_stage.sv

//--- Makefile
# Verilator build and run for the decode stage testbench

VERILATOR ?= verilator
TOP       ?= tb_mips_decode_stage
FILELIST  ?= mips_decode_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(BUILD_DIR)/V%: $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $* --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
